// ==== build.f ====
+incdir+.
alu_pkg.sv
alu_ctrl_if.sv
nibble_alu.sv
alu_sequencer.sv
flag_reg.sv
alu_unit.sv
alu_assertions.sv
alu_checker.sv
tb_alu_unit.sv

// ==== Bender.yml ====
package:
  name: nibble_alu_unit

sources:
  - include_dirs:
      - .
    files:
      - alu_pkg.sv
      - alu_ctrl_if.sv
      - nibble_alu.sv
      - alu_sequencer.sv
      - flag_reg.sv
      - alu_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - alu_assertions.sv
      - alu_checker.sv
      - tb_alu_unit.sv

// ==== tb_alu_unit.sv ====
// Testbench top: clock, reset, directed and random stimulus,
// reference model, back-pressure driver, watchdog and final report.

`include "alu_defines.svh"

module tb_alu_unit;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_DIRECTED = 22; // Requests in the directed tests.
	localparam int N_BP = 20; // Requests under back-pressure.
	localparam int N_RANDOM = 200; // Requests in the long random run.
	localparam int CYCLE_LIMIT = (N_DIRECTED + N_BP + N_RANDOM) * 8 + 100;

	logic clk;
	logic rst_n;
	logic req_valid;
	logic req_ready;
	alu_pkg::alu_op_e req_op;
	logic [`ALU_WORD_W-1:0] req_a;
	logic [`ALU_WORD_W-1:0] req_b;
	logic res_valid;
	logic res_ready;
	logic [`ALU_WORD_W-1:0] res_data;
	logic res_z;
	logic res_n;
	logic res_h;
	logic res_c;

	integer seed = 32'h632de25c; // Fixed seed for repeatable runs.
	logic bp_on; // Random res_ready when set.
	logic model_c; // Carry the flag register should hold.
	int cycles = 0;

	alu_unit i_alu_unit (.*);

	alu_checker i_checker (.*);

	bind alu_unit alu_assertions i_alu_assertions (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_op(req_op),
		.req_a(req_a),
		.req_b(req_b),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_data(res_data),
		.op_in_oe(ctrl_if.op_in_oe),
		.result_oe(ctrl_if.result_oe),
		.shift_oe(ctrl_if.shift_oe),
		.op_a_oe(ctrl_if.op_a_oe),
		.shift_l(ctrl_if.shift_l),
		.shift_r(ctrl_if.shift_r)
	);

	// ***********************************************************
	// Clock, back-pressure and watchdog
	// ***********************************************************
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period.
	end

	initial begin
		res_ready = 1'b1;
		forever begin
			@(negedge clk);
			res_ready = bp_on ? (($random(seed) & 1) != 0) : 1'b1;
		end
	end

	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycles);
		$display("Some tests failed");
		$finish;
	end

	// ***********************************************************
	// Reference model returning {byte, z, n, h, c}
	// ***********************************************************
	function automatic logic [11:0] alu_model(input alu_pkg::alu_op_e op,
		input logic [7:0] a, input logic [7:0] b, input logic c_in);
		logic [8:0] full; // Bit 8 is carry or borrow.
		logic [4:0] half; // Bit 4 is half carry or half borrow.
		logic [7:0] r;
		logic cy;
		logic z;
		logic n;
		logic h;
		logic c;
		r = 8'h00;
		n = 1'b0;
		h = 1'b0;
		c = 1'b0;
		case (op)
			alu_pkg::OP_ADD, alu_pkg::OP_ADC: begin
				cy = (op == alu_pkg::OP_ADC) ? c_in : 1'b0;
				full = a + b + cy;
				half = a[3:0] + b[3:0] + cy;
				r = full[7:0];
				h = half[4];
				c = full[8];
			end
			alu_pkg::OP_SUB, alu_pkg::OP_SBC, alu_pkg::OP_CP: begin
				cy = (op == alu_pkg::OP_SBC) ? c_in : 1'b0;
				full = {1'b0, a} - {1'b0, b} - cy; // Negative sets bit 8.
				half = {1'b0, a[3:0]} - {1'b0, b[3:0]} - cy;
				r = full[7:0];
				n = 1'b1;
				h = half[4];
				c = full[8];
			end
			alu_pkg::OP_AND: begin
				r = a & b;
				h = 1'b1; // Fixed H for AND.
			end
			alu_pkg::OP_XOR: r = a ^ b;
			alu_pkg::OP_OR: r = a | b;
			alu_pkg::OP_RL: begin
				r = {a[6:0], c_in};
				c = a[7];
			end
			default: begin // RR.
				r = {c_in, a[7:1]};
				c = a[0];
			end
		endcase
		z = (r == 8'h00); // CP takes Z from the difference.
		if (op == alu_pkg::OP_CP) begin
			r = a;
		end
		return {r, z, n, h, c};
	endfunction

	// ***********************************************************
	// Stimulus
	// ***********************************************************
	// Runs from one falling edge to the falling edge after accept.
	task automatic send(input alu_pkg::alu_op_e op, input logic [7:0] a,
		input logic [7:0] b);
		logic [11:0] exp;
		exp = alu_model(op, a, b, model_c);
		model_c = exp[0]; // Next operation sees this carry.
		i_checker.expect_result(op, exp[11:4], exp[3:0]);
		req_op = op;
		req_a = a;
		req_b = b;
		req_valid = 1'b1;
		while (!req_ready) begin
			@(negedge clk);
		end
		@(negedge clk); // Accepting edge has passed.
		req_valid = 1'b0;
	endtask

	task automatic send_random();
		logic [3:0] code;
		logic [7:0] a;
		logic [7:0] b;
		code = $unsigned($random(seed)) % 10; // One of the ten opcodes.
		a = $random(seed);
		b = $random(seed);
		send(alu_pkg::alu_op_e'(code), a, b);
	endtask

	task automatic drain();
		while (i_checker.pending() != 0) begin
			@(negedge clk);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_op = alu_pkg::OP_ADD;
		req_a = '0;
		req_b = '0;
		bp_on = 1'b0;
		model_c = 1'b0; // Flags clear out of reset.
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		i_checker.start_test("reset state");
		i_checker.check_idle();
		i_checker.finish_test();

		i_checker.start_test("directed arithmetic");
		send(alu_pkg::OP_ADD, 8'h0F, 8'h01); // Half carry.
		send(alu_pkg::OP_ADD, 8'hFF, 8'h01); // Z, H and C.
		send(alu_pkg::OP_SUB, 8'h10, 8'h01); // Half borrow.
		send(alu_pkg::OP_SUB, 8'h00, 8'h01); // Full borrow.
		send(alu_pkg::OP_CP, 8'h3C, 8'h3C); // Equal operands set Z and keep A.
		send(alu_pkg::OP_CP, 8'h20, 8'h41);
		drain();
		i_checker.finish_test();

		i_checker.start_test("carry chaining");
		send(alu_pkg::OP_ADD, 8'hFF, 8'h01); // Leaves C set.
		send(alu_pkg::OP_ADC, 8'h10, 8'h20);
		send(alu_pkg::OP_ADC, 8'hFF, 8'h00);
		send(alu_pkg::OP_SUB, 8'h00, 8'h01); // Borrow leaves C set.
		send(alu_pkg::OP_SBC, 8'h50, 8'h10);
		send(alu_pkg::OP_SBC, 8'h00, 8'h00);
		send(alu_pkg::OP_RL, 8'h80, 8'h00); // Bit 7 goes to C.
		send(alu_pkg::OP_RL, 8'h01, 8'h00);
		send(alu_pkg::OP_RR, 8'h01, 8'h00); // Bit 0 goes to C.
		send(alu_pkg::OP_RR, 8'h00, 8'h00);
		drain();
		i_checker.finish_test();

		i_checker.start_test("logic operations");
		send(alu_pkg::OP_AND, 8'hF0, 8'h3C);
		send(alu_pkg::OP_AND, 8'h0F, 8'hF0);
		send(alu_pkg::OP_OR, 8'h00, 8'h00);
		send(alu_pkg::OP_OR, 8'hA5, 8'h5A);
		send(alu_pkg::OP_XOR, 8'hAA, 8'hAA);
		send(alu_pkg::OP_XOR, 8'h0F, 8'hFF);
		drain();
		i_checker.finish_test();

		i_checker.start_test("latency and back-pressure");
		bp_on = 1'b1;
		repeat (N_BP) send_random();
		drain();
		bp_on = 1'b0;
		i_checker.finish_test();

		i_checker.start_test("random sequence");
		repeat (N_RANDOM) send_random();
		drain();
		i_checker.finish_test();

		@(negedge clk);
		i_checker.report_totals();
		if ((i_checker.error_count() == 0) &&
			(i_alu_unit.i_alu_assertions.fail_count == 0)) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== alu_checker.sv ====
// Result checker: expected-value queue, transfer comparison,
// latency and back-pressure checks, per-test and total reporting.

`include "alu_defines.svh"

module alu_checker (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input logic req_ready,
	input alu_pkg::alu_op_e req_op,
	input logic res_valid,
	input logic res_ready,
	input logic [`ALU_WORD_W-1:0] res_data,
	input logic res_z,
	input logic res_n,
	input logic res_h,
	input logic res_c
);
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		alu_pkg::alu_op_e op; // Operation, for messages.
		logic [`ALU_WORD_W-1:0] data; // Expected result byte.
		alu_pkg::alu_flags_t flags; // Expected Z N H C.
	} expect_t;

	expect_t exp_q[$]; // Results still to come, in order.
	string test_name = "none";
	int checks = 0;
	int errors = 0;
	int test_checks = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cyc = 0; // Posedge count.
	int accept_cyc = 0; // Cycle of the last accepting edge.
	alu_pkg::alu_op_e accept_op;
	logic busy = 1'b0; // Request accepted, result not yet taken.
	logic prev_valid = 1'b0;
	logic prev_ready = 1'b1;
	logic [`ALU_WORD_W+3:0] prev_payload; // Byte and flags seen last edge.

	// ***********************************************************
	// Bookkeeping
	// ***********************************************************
	task automatic expect_result(input alu_pkg::alu_op_e op,
		input logic [`ALU_WORD_W-1:0] data, input alu_pkg::alu_flags_t flags);
		expect_t e;
		e.op = op;
		e.data = data;
		e.flags = flags;
		exp_q.push_back(e);
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	function automatic int error_count();
		return errors;
	endfunction

	function automatic int expected_latency(input alu_pkg::alu_op_e op);
		if (op inside {alu_pkg::OP_RL, alu_pkg::OP_RR}) begin
			return `ALU_LAT_SHIFT; // Load and shift.
		end
		return `ALU_LAT_ARITH;
	endfunction

	task automatic report_error(input string msg);
		errors++;
		test_errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	task automatic compare_value(input string name, input logic [7:0] got,
		input logic [7:0] exp, input string where);
		checks++;
		test_checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h (%s)", name, got, exp, where);
		end
	endtask

	// ***********************************************************
	// Test framing
	// ***********************************************************
	task automatic start_test(input string name);
		test_name = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
			$display("Test %s: FAILED, %0d errors in %0d checks", test_name, test_errors,
				test_checks);
		end else begin
			$display("Test %s: ok, %0d checks", test_name, test_checks);
		end
	endtask

	task automatic report_totals();
		$display("Tests run %0d, failed %0d, checks %0d, errors %0d", tests_run,
			tests_failed, checks, errors);
	endtask

	// Idle state straight out of reset, called between clock edges.
	task automatic check_idle();
		compare_value("req_ready", req_ready, 8'h1, "after reset");
		compare_value("res_valid", res_valid, 8'h0, "after reset");
		compare_value("res_z", res_z, 8'h0, "after reset");
		compare_value("res_n", res_n, 8'h0, "after reset");
		compare_value("res_h", res_h, 8'h0, "after reset");
		compare_value("res_c", res_c, 8'h0, "after reset");
	endtask

	// ***********************************************************
	// Port monitor, values as seen just before each edge
	// ***********************************************************
	always @(posedge clk) begin
		expect_t e;
		int lat;
		cyc++;
		if (!rst_n) begin
			busy = 1'b0;
			prev_valid = 1'b0;
			prev_ready = 1'b1;
		end else begin
			if (prev_valid && !prev_ready) begin // Result stalled last edge.
				if (!res_valid) begin
					report_error("res_valid dropped before the result was taken");
				end else if ({res_data, res_z, res_n, res_h, res_c} !== prev_payload) begin
					report_error("result changed while res_ready was low");
				end
			end
			if (busy && req_ready) begin
				report_error("req_ready high while an operation was in flight");
			end
			if (res_valid && !prev_valid) begin
				lat = cyc - accept_cyc - 1; // Seen one edge after it rose.
				checks++;
				test_checks++;
				if (!busy) begin
					report_error("res_valid raised with no request accepted");
				end else if (lat != expected_latency(accept_op)) begin
					report_error($sformatf("%s result came %0d cycles after accept, not %0d",
						accept_op.name(), lat, expected_latency(accept_op)));
				end
			end
			if (res_valid && res_ready) begin // Result transfer.
				if (exp_q.size() == 0) begin
					report_error("result transfer with no expected value");
				end else begin
					e = exp_q.pop_front();
					compare_value("res_data", res_data, e.data, e.op.name());
					compare_value("res_z", res_z, e.flags.z, e.op.name());
					compare_value("res_n", res_n, e.flags.n, e.op.name());
					compare_value("res_h", res_h, e.flags.h, e.op.name());
					compare_value("res_c", res_c, e.flags.c, e.op.name());
				end
				busy = 1'b0;
			end
			if (req_valid && req_ready) begin // Request accepted.
				accept_cyc = cyc;
				accept_op = req_op;
				busy = 1'b1;
			end
			prev_valid = res_valid;
			prev_ready = res_ready;
			prev_payload = {res_data, res_z, res_n, res_h, res_c};
		end
	end

endmodule

// ==== alu_assertions.sv ====
// Bound checker with concurrent assertions on the execution unit.
// Handshake stability on both channels and core bus select rules.

module alu_assertions (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input logic req_ready,
	input alu_pkg::alu_op_e req_op,
	input logic [7:0] req_a,
	input logic [7:0] req_b,
	input logic res_valid,
	input logic res_ready,
	input logic [7:0] res_data,
	input logic op_in_oe,
	input logic result_oe,
	input logic shift_oe,
	input logic op_a_oe,
	input logic shift_l,
	input logic shift_r
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0; // Failed assertion attempts.

	// ***********************************************************
	// Handshakes
	// ***********************************************************
	req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid && !req_ready |=> req_valid && $stable({req_op, req_a, req_b}))
		else begin
			fail_count++;
			$error("request dropped or changed before it was accepted");
		end

	res_hold: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid && !res_ready |=> res_valid && $stable(res_data))
		else begin
			fail_count++;
			$error("result dropped or changed before it was taken");
		end

	// ***********************************************************
	// Core controls
	// ***********************************************************
	bus_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({op_in_oe, result_oe, shift_oe, op_a_oe}))
		else begin
			fail_count++;
			$error("more than one source drives the core bus");
		end

	shift_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(shift_l && shift_r))
		else begin
			fail_count++;
			$error("rotate left and right selected together");
		end

endmodule

// ==== alu_unit.sv ====
// Execution unit top level: plain request and result ports,
// sequencer, flag register and nibble-serial core.

`include "alu_defines.svh"

module alu_unit (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	output logic req_ready,
	input alu_pkg::alu_op_e req_op,
	input logic [`ALU_WORD_W-1:0] req_a,
	input logic [`ALU_WORD_W-1:0] req_b,
	output logic res_valid,
	input logic res_ready,
	output logic [`ALU_WORD_W-1:0] res_data,
	output logic res_z,
	output logic res_n,
	output logic res_h,
	output logic res_c
);

	alu_ctrl_if ctrl_if ();

	logic [`ALU_WORD_W-1:0] core_dout; // Core bus back to the sequencer.
	logic flag_we;
	alu_pkg::alu_flags_t next_flags;
	alu_pkg::alu_flags_t flags;

	alu_sequencer i_alu_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_op(req_op),
		.req_a(req_a),
		.req_b(req_b),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_data(res_data),
		.ctrl(ctrl_if.master),
		.core_dout(core_dout),
		.flags(flags),
		.flag_we(flag_we),
		.next_flags(next_flags)
	);

	flag_reg i_flag_reg (
		.clk(clk),
		.rst_n(rst_n),
		.flag_we(flag_we),
		.next_flags(next_flags),
		.flags(flags)
	);

	nibble_alu i_nibble_alu (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl_if.core),
		.dout(core_dout)
	);

	// Flags are stable with the result, written on the res_valid edge.
	assign res_z = flags.z;
	assign res_n = flags.n;
	assign res_h = flags.h;
	assign res_c = flags.c;

endmodule

// ==== flag_reg.sv ====
// Flag register: persistent Z N H C across operations,
// written on completion, carry exported for the next carry-in.

module flag_reg (
	input logic clk,
	input logic rst_n,
	input logic flag_we,
	input alu_pkg::alu_flags_t next_flags,
	output alu_pkg::alu_flags_t flags
);

	// ***********************************************************
	// Flag storage
	// ***********************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags <= '0; // All flags clear out of reset.
		end else if (flag_we) begin
			flags <= next_flags; // Only on the completing step.
		end
	end

	// flags.c stays valid for the whole next operation,
	// so ADC, SBC, RL and RR see the previous carry.

endmodule

// ==== alu_sequencer.sv ====
// Request and result handshakes, micro-step FSM, opcode decode
// into core controls, flag forming and result capture.

`include "alu_defines.svh"

module alu_sequencer (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	output logic req_ready,
	input alu_pkg::alu_op_e req_op,
	input logic [`ALU_WORD_W-1:0] req_a,
	input logic [`ALU_WORD_W-1:0] req_b,
	output logic res_valid,
	input logic res_ready,
	output logic [`ALU_WORD_W-1:0] res_data,
	alu_ctrl_if.master ctrl,
	input logic [`ALU_WORD_W-1:0] core_dout,
	input alu_pkg::alu_flags_t flags,
	output logic flag_we,
	output alu_pkg::alu_flags_t next_flags
);

	typedef enum logic [2:0] {
		S_IDLE, S_LOAD_A, S_LOAD_B, S_LOW, S_HIGH, S_SHIFT, S_DONE
	} state_e;

	state_e state;
	alu_pkg::alu_req_t req_q; // Request held for the whole operation.
	logic c_low; // Carry out of the low nibble.
	logic cin_low; // Carry into the low nibble.
	logic is_sub, is_rot, is_cp, is_and, is_or, is_or_xor;
	logic capture; // Take core_dout into res_data.

	assign req_ready = (state == S_IDLE);

	// ***********************************************************
	// Opcode decode
	// ***********************************************************
	assign is_sub = req_q.op inside {alu_pkg::OP_SUB, alu_pkg::OP_SBC, alu_pkg::OP_CP};
	assign is_rot = req_q.op inside {alu_pkg::OP_RL, alu_pkg::OP_RR};
	assign is_cp = (req_q.op == alu_pkg::OP_CP);
	assign is_and = (req_q.op == alu_pkg::OP_AND);
	assign is_or = (req_q.op == alu_pkg::OP_OR);
	assign is_or_xor = req_q.op inside {alu_pkg::OP_OR, alu_pkg::OP_XOR};

	always_comb begin
		case (req_q.op)
			alu_pkg::OP_ADC: cin_low = flags.c; // Stored carry.
			alu_pkg::OP_SBC: cin_low = !flags.c; // Borrow is inverted carry.
			alu_pkg::OP_SUB, alu_pkg::OP_CP: cin_low = 1'b1; // Two's complement +1.
			alu_pkg::OP_AND: cin_low = 1'b1; // Seeds the forced chain.
			default: cin_low = 1'b0;
		endcase
	end

	// ***********************************************************
	// Core controls per micro-step
	// ***********************************************************
	always_comb begin
		ctrl.din = '0;
		ctrl.load_a = 1'b0;
		ctrl.load_b = 1'b0;
		ctrl.load_a_zero = 1'b0;
		ctrl.op_in_oe = 1'b0;
		ctrl.result_oe = 1'b0;
		ctrl.shift_oe = 1'b0;
		ctrl.op_a_oe = 1'b0;
		ctrl.shift_l = 1'b0;
		ctrl.shift_r = 1'b0;
		ctrl.shift_in = 1'b0;
		ctrl.no_carry_out = 1'b0;
		ctrl.force_carry = 1'b0;
		ctrl.ignore_carry = 1'b0;
		ctrl.negate = 1'b0;
		ctrl.op_low = 1'b0;
		ctrl.carry_in = 1'b0;
		case (state)
			S_LOAD_A: begin
				ctrl.din = req_q.a;
				ctrl.op_in_oe = 1'b1;
				ctrl.load_a = 1'b1;
			end
			S_LOAD_B: begin
				ctrl.din = req_q.b;
				ctrl.op_in_oe = 1'b1;
				ctrl.load_b = 1'b1;
			end
			S_LOW, S_HIGH: begin
				ctrl.no_carry_out = is_or_xor; // R.
				ctrl.force_carry = is_and; // S.
				ctrl.ignore_carry = is_or; // V.
				ctrl.negate = is_sub;
				ctrl.op_low = (state == S_LOW);
				ctrl.carry_in = (state == S_LOW) ? cin_low : c_low;
				ctrl.op_a_oe = (state == S_LOW) && is_cp; // CP reads A back while bus is free.
				ctrl.result_oe = (state == S_HIGH);
			end
			S_SHIFT: begin
				ctrl.shift_oe = 1'b1;
				ctrl.shift_l = (req_q.op == alu_pkg::OP_RL);
				ctrl.shift_r = (req_q.op == alu_pkg::OP_RR);
				ctrl.shift_in = flags.c; // Rotate through carry.
			end
			S_DONE: ctrl.load_a_zero = res_ready; // Clear A as the result leaves.
			default: ;
		endcase
	end

	// ***********************************************************
	// Flags
	// ***********************************************************
	always_comb begin
		next_flags = '0;
		flag_we = 1'b0;
		if (state == S_HIGH) begin
			flag_we = 1'b1;
			next_flags.z = ctrl.zero; // Result on the bus.
			next_flags.n = is_sub;
			if (is_and) begin
				next_flags.h = 1'b1;
				next_flags.c = 1'b0;
			end else if (is_or_xor) begin
				next_flags.h = 1'b0;
				next_flags.c = 1'b0;
			end else begin
				next_flags.h = c_low ^ is_sub; // Borrow is the missing carry.
				next_flags.c = ctrl.carry ^ is_sub;
			end
		end else if (state == S_SHIFT) begin
			flag_we = 1'b1;
			next_flags.z = ctrl.zero;
			next_flags.c = (req_q.op == alu_pkg::OP_RL) ? ctrl.shift_dbh : ctrl.shift_dbl;
		end
	end

	// CP keeps A, taken in the low step; others take the final bus.
	assign capture = ((state == S_LOW) && is_cp) || ((state == S_HIGH) && !is_cp) ||
		(state == S_SHIFT);

	// ***********************************************************
	// FSM and payload
	// ***********************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			res_valid <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (req_valid) state <= S_LOAD_A;
				S_LOAD_A: state <= is_rot ? S_SHIFT : S_LOAD_B;
				S_LOAD_B: state <= S_LOW;
				S_LOW: state <= S_HIGH;
				S_HIGH, S_SHIFT: begin
					state <= S_DONE;
					res_valid <= 1'b1; // Same edge as the flag write.
				end
				S_DONE: begin
					if (res_ready) begin
						state <= S_IDLE;
						res_valid <= 1'b0;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			req_q <= '{op: req_op, a: req_a, b: req_b};
		end
		if (state == S_LOW) begin
			c_low <= ctrl.carry; // Chains into the high pass.
		end
		if (capture) begin
			res_data <= core_dout;
		end
	end

endmodule

// ==== nibble_alu.sv ====
// Nibble-serial ALU core: operand registers, R/S/V carry slices,
// rotate shifter, bus multiplexer and low-nibble result latch.

`include "alu_defines.svh"

module nibble_alu (
	input logic clk,
	input logic rst_n,
	alu_ctrl_if.core ctrl,
	output logic [`ALU_WORD_W-1:0] dout
);

	logic [`ALU_WORD_W-1:0] op_a, op_b; // Operand registers.
	logic [`ALU_WORD_W-1:0] shifted; // A rotated by one place.
	logic [`ALU_WORD_W-1:0] bus; // Internal ALU bus.
	logic [`ALU_NIB_W-1:0] core_op_a, core_op_b; // Nibbles fed to the slices.
	logic [`ALU_NIB_W-1:0] core_result; // Slice outputs this cycle.
	logic [`ALU_NIB_W-1:0] res_lo; // Latched low nibble.

	// ***********************************************************
	// Carry slice
	// ***********************************************************
	// R kills carry out, S forces it, V folds the carry into the sum.
	// Add is R=S=V=0; XOR is R; OR is R+V; AND is S with carry in set.
	function automatic logic [1:0] alu_slice(
		input logic a,
		input logic b,
		input logic c_in,
		input logic r_sig,
		input logic s_sig,
		input logic v_sig
	);
		logic nc;
		logic r;
		logic c_out;
		nc = !(((a | b) & c_in) | (a & b) | s_sig); // Low when a carry is made.
		r = (a & b & c_in) | ((a | b | c_in) & (v_sig | nc));
		c_out = !(r_sig | nc);
		return {c_out, r};
	endfunction

	// Same select picks the A and B halves.
	assign core_op_a = ctrl.op_low ? op_a[`ALU_NIB_W-1:0] : op_a[`ALU_WORD_W-1:`ALU_NIB_W];

	always_comb begin
		logic [`ALU_NIB_W-1:0] b_half;
		b_half = ctrl.op_low ? op_b[`ALU_NIB_W-1:0] : op_b[`ALU_WORD_W-1:`ALU_NIB_W];
		core_op_b = ctrl.negate ? ~b_half : b_half; // Subtract is A + ~B + 1.
	end

	// Ripple through four slices in one cycle.
	always_comb begin
		logic [`ALU_NIB_W-1:0] r;
		logic [1:0] s;
		logic c;
		c = ctrl.carry_in;
		for (int i = 0; i < `ALU_NIB_W; i++) begin
			s = alu_slice(core_op_a[i], core_op_b[i], c,
				ctrl.no_carry_out, ctrl.force_carry, ctrl.ignore_carry);
			r[i] = s[0];
			c = s[1];
		end
		core_result = r;
		ctrl.carry = c; // Nibble carry out.
	end

	// ***********************************************************
	// Shifter and bus
	// ***********************************************************
	always_comb begin
		shifted = op_a; // No rotate selected.
		if (ctrl.shift_l) begin
			shifted = {op_a[`ALU_WORD_W-2:0], ctrl.shift_in};
		end else if (ctrl.shift_r) begin
			shifted = {ctrl.shift_in, op_a[`ALU_WORD_W-1:1]};
		end
	end

	assign ctrl.shift_dbh = op_a[`ALU_WORD_W-1]; // Bit lost by RL.
	assign ctrl.shift_dbl = op_a[0]; // Bit lost by RR.

	always_comb begin
		bus = '0; // Idle bus reads zero.
		unique0 case (1'b1)
			ctrl.op_in_oe: bus = ctrl.din;
			ctrl.result_oe: bus = {core_result, res_lo}; // High nibble live, low latched.
			ctrl.shift_oe: bus = shifted;
			ctrl.op_a_oe: bus = op_a;
		endcase
	end

	assign dout = bus;
	assign ctrl.zero = (bus == '0);

	// ***********************************************************
	// Registers
	// ***********************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			op_a <= '0;
		end else if (ctrl.load_a_zero) begin
			op_a <= '0;
		end else if (ctrl.load_a) begin
			op_a <= bus;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			op_b <= '0;
		end else if (ctrl.load_b) begin
			op_b <= bus;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_lo <= '0;
		end else if (ctrl.op_low) begin
			res_lo <= core_result; // Low half waits for the high pass.
		end
	end

endmodule

// ==== alu_ctrl_if.sv ====
// Micro-step control bundle from the sequencer to the nibble-serial core.

`include "alu_defines.svh"

interface alu_ctrl_if;

	logic [`ALU_WORD_W-1:0] din; // Request byte offered to the bus.
	logic load_a, load_b; // Load bus into A or B.
	logic load_a_zero; // Clear A.
	logic op_in_oe, result_oe; // Bus source: din or core result.
	logic shift_oe, op_a_oe; // Bus source: shifted A or A itself.
	logic shift_l, shift_r; // Rotate direction.
	logic shift_in; // Bit entering the rotate.
	logic no_carry_out; // R, kills the slice carry.
	logic force_carry; // S, forces the slice carry.
	logic ignore_carry; // V, ORs the carry into the sum.
	logic negate; // Invert B into the core.
	logic op_low; // Low nibble select, also latches it.
	logic carry_in; // Carry into bit 0 of the nibble.
	logic carry; // Carry out of the nibble.
	logic zero; // Bus is all zero.
	logic shift_dbh, shift_dbl; // MSB and LSB of A.

	modport master (
		output din, load_a, load_b, load_a_zero, op_in_oe, result_oe, shift_oe, op_a_oe,
		output shift_l, shift_r, shift_in, no_carry_out, force_carry, ignore_carry,
		output negate, op_low, carry_in,
		input carry, zero, shift_dbh, shift_dbl
	);

	modport core (
		input din, load_a, load_b, load_a_zero, op_in_oe, result_oe, shift_oe, op_a_oe,
		input shift_l, shift_r, shift_in, no_carry_out, force_carry, ignore_carry,
		input negate, op_low, carry_in,
		output carry, zero, shift_dbh, shift_dbl
	);

endinterface

// ==== alu_pkg.sv ====
// Opcode enumeration, flag struct and request struct of the execution unit.

`include "alu_defines.svh"

package alu_pkg;

	// Operations handled by the unit; DAA and bit ops are not present.
	typedef enum logic [3:0] {
		OP_ADD = 4'd0, // A + B.
		OP_ADC = 4'd1, // A + B + C.
		OP_SUB = 4'd2, // A - B.
		OP_SBC = 4'd3, // A - B - C.
		OP_AND = 4'd4, // A & B, H set.
		OP_XOR = 4'd5, // A ^ B.
		OP_OR = 4'd6, // A | B.
		OP_CP = 4'd7, // Compare, A - B with A kept.
		OP_RL = 4'd8, // Rotate A left through carry.
		OP_RR = 4'd9 // Rotate A right through carry.
	} alu_op_e;

	// SM83 flag order, Z in the MSB.
	typedef struct packed {
		logic z; // Result is zero.
		logic n; // Last operation was a subtract.
		logic h; // Carry or borrow out of bit 3.
		logic c; // Carry or borrow out of bit 7, or rotated-out bit.
	} alu_flags_t;

	// One request as seen on the input channel.
	typedef struct packed {
		alu_op_e op; // Opcode.
		logic [`ALU_WORD_W-1:0] a; // Operand A.
		logic [`ALU_WORD_W-1:0] b; // Operand B.
	} alu_req_t;

endpackage

// ==== alu_defines.svh ====
// Width and latency macros for the nibble-serial execution unit.
// Shared by the package, the interface, the RTL and the testbench.

`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// ***********************************************************
// Datapath widths
// ***********************************************************
`define ALU_WORD_W 8 // Byte operands and result.
`define ALU_NIB_W 4 // One half of the byte, the core slice width.

// ***********************************************************
// Latencies, accepting edge to res_valid
// ***********************************************************
`define ALU_LAT_ARITH 4 // Load A, load B, low nibble, high nibble.
`define ALU_LAT_SHIFT 2 // Load A, shift.

`endif
